/* inst_fetch_top.f */
hdl/inst_fetch_pkg.sv
hdl/fetch_ctrl.sv
hdl/burst_splitter.sv
hdl/inst_mem.sv
hdl/tile_decoder.sv
hdl/inst_fetch_top.sv
sim/tb_inst_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run the testbench, then decide from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_inst_fetch \
    -f inst_fetch_top.f -o tb_inst_fetch > build.log 2>&1 \
    && ./obj_dir/tb_inst_fetch > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -qx "All tests passed" sim.log && exit 0 || exit 1

/* sim/tb_inst_fetch.sv */
module tb_inst_fetch
    import inst_fetch_pkg::*;
();

    localparam int PE_CREDITS = 2;
    // 3 runs x (256 beats x 4 stall + 128 tiles x 25) rounded up
    localparam int TIMEOUT    = 15000;

    logic              clk;
    logic              rst;
    logic              start;
    logic [ADDR_W-1:0] inst_base;
    logic [15:0]       inst_count;
    axi_ar_t           ar;
    logic              arvalid;
    logic              arready;
    axi_r_t            r;
    logic              rvalid;
    logic              rready;
    tile_desc_t        tile;
    logic              tile_valid;
    logic              pe_credit;
    logic              done;
    logic              rd_error;
    logic [ADDR_W-1:0] rd_error_addr;

    integer            seed;
    int                errors = 0;
    int                cycles = 0;
    string             test_name = "reset";
    logic [INST_W-1:0] dram [1024];      // DRAM image, 0x0000 to 0x3fff
    logic [ADDR_W-1:0] err_addr;         // Beat that answers with SLVERR
    int                credit_due [$];   // Cycle at which each held tile frees

    // Monitor state cleared at every start edge
    logic              start_q = 1'b0;
    logic              started;
    logic              err_armed = 1'b0;
    logic [ADDR_W-1:0] run_base = '0;
    logic [ADDR_W-1:0] exp_ar_addr = '0;
    int                burst_beats = 0;
    int                tiles_seen = 0;
    int                outstanding = 0;
    int                done_seen = 0;
    int                bursts_total = 0;
    int                tiles_total = 0;

    inst_fetch_top #(
        .INST_DEPTH (256),
        .PE_CREDITS (PE_CREDITS)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .inst_base     (inst_base),
        .inst_count    (inst_count),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .tile          (tile),
        .tile_valid    (tile_valid),
        .pe_credit     (pe_credit),
        .done          (done),
        .rd_error      (rd_error),
        .rd_error_addr (rd_error_addr)
    );

    function automatic logic [INST_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
        return dram[addr[13:4]];
    endfunction

    // Word 2k holds the addresses and word 2k+1 the tile fields
    function automatic tile_desc_t decode_pair(input logic [INST_W-1:0] aw,
                                               input logic [INST_W-1:0] cw);
        tile_desc_t t;
        t.pooling_addr    = aw[127:96];
        t.input_addr      = aw[95:64];
        t.weight_addr     = aw[63:32];
        t.output_addr     = aw[31:0];
        t.is_last_channel = cw[0];
        t.have_accumulate = cw[1];
        t.is_final_tile   = cw[2];
        t.tile_type       = cw[6:3];
        t.tile_row        = cw[12:7];
        t.tile_col        = cw[18:13];
        t.have_maxpool    = cw[19];
        return t;
    endfunction

    task automatic report_mismatch(input string what, input logic [159:0] exp,
                                   input logic [159:0] act);
        errors++;
        $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    endtask

    ////////////////////
    // Clock and models
    ////////////////////

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin : ar_ready_gen
        arready <= (({$random(seed)} % 3) != 0);   // Ready two times in three
    end

    // AXI read slave serving one burst at a time with random beat gaps
    initial begin : dram_slave
        logic [ADDR_W-1:0] addr;
        int                len;
        forever begin
            rvalid <= 1'b0;
            @(posedge clk);
            if (!rst && arvalid && arready) begin
                addr = ar.addr;
                len  = int'(ar.len);
                for (int i = 0; i <= len; i++) begin
                    while (({$random(seed)} % 4) == 0) begin
                        rvalid <= 1'b0;
                        @(posedge clk);
                    end
                    rvalid <= 1'b1;
                    r.data <= word_at(addr);
                    r.resp <= (addr == err_addr) ? 2'b10 : RESP_OKAY;
                    r.last <= (i == len);
                    addr   = addr + ADDR_W'(BEAT_BYTES);
                    @(posedge clk);
                end
            end
        end
    end

    // PE holds each tile for 1 to 20 cycles
    always @(posedge clk) begin : pe_model
        if (rst) begin
            pe_credit <= 1'b0;
        end else begin
            pe_credit <= 1'b0;
            if (tile_valid) begin
                credit_due.push_back(cycles + 1 + int'({$random(seed)} % 20));
            end
            if (credit_due.size() > 0 && credit_due[0] <= cycles) begin
                void'(credit_due.pop_front());
                pe_credit <= 1'b1;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && ar == $past(ar))
        else begin
            errors++;
            $display("AR request dropped or changed before arready in %s", test_name);
        end

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        outstanding <= PE_CREDITS)
        else begin
            errors++;
            $display("More than %0d tiles held by the PE in %s", PE_CREDITS, test_name);
        end

    always @(posedge clk) begin : monitor
        tile_desc_t        exp_tile;
        logic [ADDR_W-1:0] pair_addr;
        if (!rst) begin
            assert (rready) else report_mismatch("rready", 160'(1), 160'(rready));
            if (!started) begin
                assert (!arvalid && !tile_valid && !done) else begin
                    errors++;
                    $display("DUT output went active before the first start");
                end
            end
            if (start && !start_q) begin
                run_base    = inst_base;
                exp_ar_addr = inst_base;   // First burst starts at the base
                burst_beats = 0;
                tiles_seen  = 0;
                done_seen   = 0;
            end
            if (arvalid && arready) begin
                assert (ar.addr == exp_ar_addr)
                    else report_mismatch("burst address", 160'(exp_ar_addr), 160'(ar.addr));
                assert (int'(ar.addr[11:0]) + (int'(ar.len) + 1) * BEAT_BYTES <= PAGE_BYTES)
                    else begin
                        errors++;
                        $display("Burst at %h with len %0d crosses a 4 KB page", ar.addr, ar.len);
                    end
                exp_ar_addr = ar.addr + ADDR_W'((int'(ar.len) + 1) * BEAT_BYTES);
                burst_beats += int'(ar.len) + 1;
                bursts_total++;
            end
            if (err_armed) begin
                assert (rd_error && rd_error_addr == err_addr)
                    else report_mismatch("rd_error_addr", 160'(err_addr), 160'(rd_error_addr));
            end else begin
                assert (!rd_error) else report_mismatch("rd_error", 160'(0), 160'(rd_error));
            end
            if (rvalid && r.resp != RESP_OKAY) begin
                err_armed = 1'b1;   // Error is visible from the next edge on
            end
            if (tile_valid) begin
                pair_addr = run_base + ADDR_W'(tiles_seen * 2 * BEAT_BYTES);
                exp_tile  = decode_pair(word_at(pair_addr), word_at(pair_addr + 32'd16));
                assert (tile == exp_tile)
                    else report_mismatch($sformatf("tile %0d", tiles_seen),
                                         160'(exp_tile), 160'(tile));
                tiles_seen++;
                tiles_total++;
                outstanding++;
            end
            if (pe_credit) begin
                outstanding--;
            end
            if (done) begin
                assert (tiles_seen == int'(inst_count) / 2)
                    else report_mismatch("tiles at done", 160'(inst_count / 2), 160'(tiles_seen));
                assert (outstanding == 0)
                    else report_mismatch("credits out at done", 160'(0), 160'(outstanding));
                done_seen++;
            end
        end
        start_q = start;
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, %s never finished", cycles, test_name);
            $display("Summary: %0d errors, %0d bursts, %0d tiles", errors, bursts_total,
                     tiles_total);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic run_fetch(input string name, input logic [ADDR_W-1:0] base,
                             input logic [15:0] count, input logic inject);
        test_name = name;
        @(posedge clk);
        inst_base  <= base;
        inst_count <= count;
        err_addr   <= inject ? base + 32'd80 : '1;   // Beat 5 of the run
        start      <= 1'b1;
        started    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        while (done_seen == 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);   // Room for a stray second done
        assert (done_seen == 1) else report_mismatch("done pulses", 160'(1), 160'(done_seen));
        assert (burst_beats == int'(count))
            else report_mismatch("burst beats", 160'(count), 160'(burst_beats));
        if (inject) begin
            assert (err_armed) else begin
                errors++;
                $display("No error response reached the DUT in %s", name);
            end
        end
    endtask

    initial begin : stimulus
        seed = 32'h3c05;
        for (int i = 0; i < 1024; i++) begin
            dram[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        rst        = 1'b1;
        start      = 1'b0;
        started    = 1'b0;
        inst_base  = '0;
        inst_count = '0;
        arready    = 1'b0;
        r          = '0;
        rvalid     = 1'b0;
        pe_credit  = 1'b0;
        err_addr   = '1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        run_fetch("page_cross", 32'h0000_0f80, 16'd20, 1'b0);
        run_fetch("full_burst", 32'h0000_2000, 16'd256, 1'b0);
        run_fetch("read_error", 32'h0000_1f00, 16'd256, 1'b1);   // Error stays sticky so this runs last
        $display("Summary: %0d errors, %0d bursts, %0d tiles", errors, bursts_total, tiles_total);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* hdl/inst_fetch_top.sv */
module inst_fetch_top
    import inst_fetch_pkg::*;
#(
    parameter  int INST_DEPTH = 256,
    parameter  int PE_CREDITS = 2,
    localparam int AW         = $clog2(INST_DEPTH)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [ADDR_W-1:0] inst_base,
    input  logic [15:0]       inst_count,
    output axi_ar_t           ar,
    output logic              arvalid,
    input  logic              arready,
    input  axi_r_t            r,
    input  logic              rvalid,
    output logic              rready,
    output tile_desc_t        tile,
    output logic              tile_valid,
    input  logic              pe_credit,
    output logic              done,
    output logic              rd_error,
    output logic [ADDR_W-1:0] rd_error_addr
);

    logic              fetch_go;
    logic [ADDR_W-1:0] fetch_base;
    logic [15:0]       fetch_count;
    logic              decode_go;
    logic              decode_done;
    logic              last_beat;
    logic              mem_we;
    logic [AW-1:0]     mem_waddr;
    logic [INST_W-1:0] mem_wdata;
    logic [AW-1:0]     mem_raddr;
    logic [INST_W-1:0] mem_rdata;

    assign rready    = 1'b1;            // Instruction memory always has room
    assign last_beat = rvalid & r.last;

    fetch_ctrl #(
        .INST_DEPTH (INST_DEPTH)
    ) i_fetch_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .inst_base     (inst_base),
        .inst_count    (inst_count),
        .r             (r),
        .rvalid        (rvalid),
        .fetch_go      (fetch_go),
        .fetch_base    (fetch_base),
        .fetch_count   (fetch_count),
        .mem_we        (mem_we),
        .mem_waddr     (mem_waddr),
        .mem_wdata     (mem_wdata),
        .decode_go     (decode_go),
        .decode_done   (decode_done),
        .done          (done),
        .rd_error      (rd_error),
        .rd_error_addr (rd_error_addr)
    );

    burst_splitter i_burst_splitter (
        .clk         (clk),
        .rst         (rst),
        .fetch_go    (fetch_go),
        .fetch_base  (fetch_base),
        .fetch_count (fetch_count),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .last_beat   (last_beat)
    );

    inst_mem #(
        .INST_DEPTH (INST_DEPTH)
    ) i_inst_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

    tile_decoder #(
        .INST_DEPTH (INST_DEPTH),
        .PE_CREDITS (PE_CREDITS)
    ) i_tile_decoder (
        .clk         (clk),
        .rst         (rst),
        .decode_go   (decode_go),
        .fetch_count (fetch_count),
        .mem_raddr   (mem_raddr),
        .mem_rdata   (mem_rdata),
        .tile        (tile),
        .tile_valid  (tile_valid),
        .pe_credit   (pe_credit),
        .decode_done (decode_done)
    );

endmodule

/* hdl/tile_decoder.sv */
module tile_decoder
    import inst_fetch_pkg::*;
#(
    parameter  int INST_DEPTH = 256,
    parameter  int PE_CREDITS = 2,
    localparam int AW         = $clog2(INST_DEPTH),
    localparam int CW         = $clog2(PE_CREDITS + 1)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              decode_go,
    input  logic [15:0]       fetch_count,
    output logic [AW-1:0]     mem_raddr,
    input  logic [INST_W-1:0] mem_rdata,
    output tile_desc_t        tile,
    output logic              tile_valid,
    input  logic              pe_credit,
    output logic              decode_done
);

    dec_state_e        state;
    logic [14:0]       tile_cnt;     // Tiles issued so far
    logic [CW-1:0]     credits;
    logic [CW:0]       credit_sum;   // Count including a return this cycle
    logic [INST_W-1:0] addr_word;
    logic              all_issued;
    logic              issue;
    tile_desc_t        next_tile;

    assign all_issued = (tile_cnt == fetch_count[15:1]);
    assign issue      = (state == DS_ISSUE) && !all_issued && (credits != '0);
    assign credit_sum = {1'b0, credits} + {{CW{1'b0}}, pe_credit};

    // Finished once every tile is out and the PE has handed all credits back
    assign decode_done = (state == DS_ISSUE) && all_issued
                         && (credit_sum == (CW + 1)'(PE_CREDITS));

    // Word 2k in RD_ADDR, word 2k+1 from RD_CFG on
    assign mem_raddr = {tile_cnt[AW-2:0], state != DS_RD_ADDR};

    ////////////////////
    // Descriptor assembly
    ////////////////////

    always_comb begin
        {next_tile.pooling_addr, next_tile.input_addr,
         next_tile.weight_addr, next_tile.output_addr} = addr_word;
        next_tile.is_last_channel = mem_rdata[0];
        next_tile.have_accumulate = mem_rdata[1];
        next_tile.is_final_tile   = mem_rdata[2];
        next_tile.tile_type       = mem_rdata[6:3];
        next_tile.tile_row        = mem_rdata[12:7];
        next_tile.tile_col        = mem_rdata[18:13];
        next_tile.have_maxpool    = mem_rdata[19];    // Upper bits unused
    end

    always_ff @(posedge clk) begin
        if (state == DS_RD_CFG) begin
            addr_word <= mem_rdata;   // Address word has just arrived
        end
        if (issue) begin
            tile <= next_tile;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= DS_IDLE;
            tile_cnt   <= '0;
            tile_valid <= 1'b0;
        end else begin
            tile_valid <= 1'b0;
            case (state)
                DS_IDLE: begin
                    if (decode_go) begin
                        state    <= DS_RD_ADDR;
                        tile_cnt <= '0;
                    end
                end
                DS_RD_ADDR: state <= DS_RD_CFG;
                DS_RD_CFG:  state <= DS_ISSUE;
                DS_ISSUE: begin
                    if (issue) begin
                        tile_valid <= 1'b1;
                        tile_cnt   <= tile_cnt + 15'd1;
                        if (tile_cnt + 15'd1 != fetch_count[15:1]) begin
                            state <= DS_RD_ADDR;
                        end
                    end else if (decode_done) begin
                        state <= DS_IDLE;
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    ////////////////////
    // PE credit counter
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst || decode_go) begin
            credits <= CW'(PE_CREDITS);
        end else if (issue && !pe_credit) begin
            credits <= credits - CW'(1);
        end else if (pe_credit && !issue) begin
            credits <= credits + CW'(1);
        end
    end

endmodule

/* hdl/inst_mem.sv */
module inst_mem
    import inst_fetch_pkg::*;
#(
    parameter  int INST_DEPTH = 256,
    localparam int AW         = $clog2(INST_DEPTH)
) (
    input  logic              clk,
    input  logic              we,
    input  logic [AW-1:0]     waddr,
    input  logic [INST_W-1:0] wdata,
    input  logic [AW-1:0]     raddr,
    output logic [INST_W-1:0] rdata
);

    logic [INST_W-1:0] mem [INST_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read gives data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* hdl/burst_splitter.sv */
module burst_splitter
    import inst_fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_go,
    input  logic [ADDR_W-1:0] fetch_base,
    input  logic [15:0]       fetch_count,
    output axi_ar_t           ar,
    output logic              arvalid,
    input  logic              arready,
    input  logic              last_beat
);

    localparam int BEAT_SH = $clog2(BEAT_BYTES);
    localparam int PAGE_W  = $clog2(PAGE_BYTES);

    split_state_e      state;
    logic [ADDR_W-1:0] next_addr;    // Start of the next burst
    logic [15:0]       beats_left;
    logic [16:0]       page_beats;   // Room left in the current page
    logic [16:0]       burst_beats;

    // Burst size is the smaller of the beats left and the page room
    always_comb begin
        page_beats  = 17'((PAGE_BYTES - int'(next_addr[PAGE_W-1:0])) >> BEAT_SH);
        burst_beats = {1'b0, beats_left};
        if (page_beats < burst_beats) begin
            burst_beats = page_beats;
        end
    end

    assign ar.addr = next_addr;
    assign ar.len  = 8'(burst_beats - 17'd1);
    assign arvalid = (state == SP_ADDR);   // Held until arready

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SP_IDLE;
            beats_left <= '0;
        end else begin
            case (state)
                SP_IDLE: begin
                    if (fetch_go) begin
                        state      <= SP_ADDR;
                        beats_left <= fetch_count;
                    end
                end
                SP_ADDR: begin
                    if (arready) begin
                        state      <= SP_DATA;
                        beats_left <= beats_left - burst_beats[15:0];
                    end
                end
                SP_DATA: begin
                    // Next AR only after the last beat of this burst
                    if (last_beat) begin
                        state <= (beats_left == '0) ? SP_IDLE : SP_ADDR;
                    end
                end
                default: state <= SP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SP_IDLE && fetch_go) begin
            next_addr <= fetch_base;
        end else if (arvalid && arready) begin
            next_addr <= next_addr + (ADDR_W'(burst_beats) << BEAT_SH);
        end
    end

endmodule

/* hdl/fetch_ctrl.sv */
module fetch_ctrl
    import inst_fetch_pkg::*;
#(
    parameter  int INST_DEPTH = 256,
    localparam int AW         = $clog2(INST_DEPTH)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [ADDR_W-1:0] inst_base,
    input  logic [15:0]       inst_count,
    input  axi_r_t            r,
    input  logic              rvalid,
    output logic              fetch_go,
    output logic [ADDR_W-1:0] fetch_base,
    output logic [15:0]       fetch_count,
    output logic              mem_we,
    output logic [AW-1:0]     mem_waddr,
    output logic [INST_W-1:0] mem_wdata,
    output logic              decode_go,
    input  logic              decode_done,
    output logic              done,
    output logic              rd_error,
    output logic [ADDR_W-1:0] rd_error_addr
);

    localparam int BEAT_SH = $clog2(BEAT_BYTES);

    fetch_state_e state;
    logic         start_q;
    logic         start_edge;
    logic [15:0]  beat_cnt;    // Beats accepted in this fetch

    assign start_edge = start & ~start_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    ////////////////////
    // Main FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= FS_IDLE;
            fetch_go  <= 1'b0;
            decode_go <= 1'b0;
            done      <= 1'b0;
        end else begin
            fetch_go  <= 1'b0;
            decode_go <= 1'b0;
            done      <= 1'b0;
            case (state)
                FS_IDLE: begin
                    if (start_edge) begin
                        state    <= FS_FETCH;
                        fetch_go <= 1'b1;
                    end
                end
                FS_FETCH: begin
                    if (rvalid && beat_cnt == fetch_count - 16'd1) begin
                        state     <= FS_DECODE;  // Last word is in memory
                        decode_go <= 1'b1;
                    end
                end
                FS_DECODE: begin
                    if (decode_done) begin
                        state <= FS_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FS_IDLE && start_edge) begin
            fetch_base  <= inst_base;
            fetch_count <= inst_count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (state == FS_IDLE && start_edge) begin
            beat_cnt <= '0;
        end else if (mem_we) begin
            beat_cnt <= beat_cnt + 16'd1;
        end
    end

    // Every accepted beat goes straight to the next word
    assign mem_we    = (state == FS_FETCH) & rvalid;
    assign mem_waddr = beat_cnt[AW-1:0];
    assign mem_wdata = r.data;

    ////////////////////
    // Read error capture
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_error      <= 1'b0;
            rd_error_addr <= '0;
        end else if (mem_we && r.resp != RESP_OKAY && !rd_error) begin
            rd_error      <= 1'b1;   // Sticky so the first error wins
            rd_error_addr <= fetch_base + (ADDR_W'(beat_cnt) << BEAT_SH);
        end
    end

endmodule

/* hdl/inst_fetch_pkg.sv */
package inst_fetch_pkg;

    ////////////////////
    // Bus and memory geometry
    ////////////////////

    localparam int INST_W     = 128;   // One instruction word per beat
    localparam int ADDR_W     = 32;
    localparam int BEAT_BYTES = 16;
    localparam int PAGE_BYTES = 4096;  // Bursts never cross this
    localparam int MAX_BURST  = 256;   // AXI4 INCR limit

    localparam logic [1:0] RESP_OKAY = 2'b00;

    ////////////////////
    // Channel payloads
    ////////////////////

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;    // Beats minus one
    } axi_ar_t;

    typedef struct packed {
        logic [INST_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    // Tile descriptor handed to the PE array
    typedef struct packed {
        logic [ADDR_W-1:0] output_addr;
        logic [ADDR_W-1:0] weight_addr;
        logic [ADDR_W-1:0] input_addr;
        logic [ADDR_W-1:0] pooling_addr;
        logic [5:0]        tile_row;
        logic [5:0]        tile_col;
        logic [3:0]        tile_type;
        logic              is_final_tile;
        logic              have_accumulate;
        logic              is_last_channel;
        logic              have_maxpool;
    } tile_desc_t;

    ////////////////////
    // FSM states
    ////////////////////

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_FETCH,
        FS_DECODE
    } fetch_state_e;

    typedef enum logic [1:0] {
        SP_IDLE,
        SP_ADDR,   // AR held until accepted
        SP_DATA    // Waiting for the last beat
    } split_state_e;

    typedef enum logic [1:0] {
        DS_IDLE,
        DS_RD_ADDR,
        DS_RD_CFG,
        DS_ISSUE
    } dec_state_e;

endpackage
